/* multiports_vdma.f */
logic/vdma_pkg.sv
logic/pixel_packer.sv
logic/word_fifo.sv
logic/vdma_write_port.sv
logic/burst_arbiter.sv
logic/app_native_bridge.sv
logic/multiports_vdma.sv
tb/multiports_vdma_tb.sv

/* Bender.yml */
package:
  name: multiports_vdma

sources:
  - logic/vdma_pkg.sv
  - logic/pixel_packer.sv
  - logic/word_fifo.sv
  - logic/vdma_write_port.sv
  - logic/burst_arbiter.sv
  - logic/app_native_bridge.sv
  - logic/multiports_vdma.sv
  - target: test
    files:
      - tb/multiports_vdma_tb.sv

/* tb/multiports_vdma_tb.sv */
`timescale 1ns/1ps

module multiports_vdma_tb;
    import vdma_pkg::*;

    localparam int NUM_CH       = 2;
    localparam int BURST_LEN    = 8;
    localparam int FIFO_DEPTH   = 32;
    localparam int MAX_FR       = 8;
    localparam int MAX_PIX      = 160;
    // pixels over every frame of the run
    localparam int TOTAL_PIX    = 64 + 64 + 2 * 64 + 2 * 67 + 2 * 67 + 2 * 64;
    localparam int WATCHDOG_CYC = TOTAL_PIX * 20 + 2000;

    logic                       axi_m00_inf;
    logic                       rst_n;
    logic                       ch_rev_enable [NUM_CH];
    logic [ASIZE-1:0]           wr_baseaddr   [NUM_CH];
    video_in_t                  vin           [NUM_CH];
    logic                       app_rdy;
    logic                       app_wdf_rdy;
    logic                       init_calib_complete;
    logic [ASIZE-1:0]           app_addr;
    app_cmd_e                   app_cmd;
    logic                       app_en;
    logic [AXI_DSIZE-1:0]       app_wdf_data;
    logic                       app_wdf_end;
    logic [AXI_DSIZE/8-1:0]     app_wdf_mask;
    logic                       app_wdf_wren;
    logic [NUM_CH-1:0]          overflow;

    // stimulus side, two generators so pixels and stalls never share a step
    logic [31:0]      lfsr_px;
    logic [31:0]      lfsr_rd;
    logic             stall_en;
    int               rdy_hold;
    int               wdf_hold;
    int               frame_no [NUM_CH];
    logic [PIX_W-1:0] pix_log  [NUM_CH][MAX_FR][MAX_PIX];
    logic [ASIZE-1:0] base_log [NUM_CH][MAX_FR];

    // check side
    int                   chk_fr  [NUM_CH];
    int                   chk_ix  [NUM_CH];
    int                   exp_cnt [NUM_CH];
    logic [ASIZE-1:0]     cmd_q [$];
    logic [AXI_DSIZE-1:0] dat_q [$];
    int                   run_cnt;
    int                   run_ch;
    logic [ASIZE-1:0]     run_addr;
    int                   beat_cnt;
    int                   mismatch_cnt;
    int                   other_cnt;

    multiports_vdma #(
        .NUM_CH     (NUM_CH),
        .BURST_LEN  (BURST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .axi_m00_inf         (axi_m00_inf),
        .rst_n               (rst_n),
        .ch_rev_enable       (ch_rev_enable),
        .wr_baseaddr         (wr_baseaddr),
        .vin                 (vin),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .init_calib_complete (init_calib_complete),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_end         (app_wdf_end),
        .app_wdf_mask        (app_wdf_mask),
        .app_wdf_wren        (app_wdf_wren),
        .overflow            (overflow)
    );

    // 4 ns period
    always #2 axi_m00_inf = ~axi_m00_inf;

    // --------------------------------------------------
    // random source and reference model
    // --------------------------------------------------
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_step(st);
        end
    endtask

    // expected beat for word ix of a frame, pixel 0 in the low bits
    function automatic app_beat_t ref_beat(input int ch, input int fr, input int ix);
        app_beat_t r;
        r.addr = base_log[ch][fr] + ASIZE'(ix * BEAT_BYTES);
        for (int p = 0; p < PIX_PER_WORD; p++) begin
            r.data[p*PIX_W +: PIX_W] = pix_log[ch][fr][ix*PIX_PER_WORD + p];
        end
        return r;
    endfunction

    // bases are disjoint, channel 1 lives at 0x200000 and up
    function automatic int chan_of(input logic [ASIZE-1:0] a);
        return (a >= ASIZE'(27'h200000)) ? 1 : 0;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            n += exp_cnt[ch];
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [AXI_DSIZE-1:0] got,
                                   input logic [AXI_DSIZE-1:0] exp);
        $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        mismatch_cnt++;
    endtask

    // one command paired with its write data
    task automatic check_pair(input logic [ASIZE-1:0] addr, input logic [AXI_DSIZE-1:0] data);
        int        ch;
        app_beat_t e;
        ch = chan_of(addr);
        beat_cnt++;
        if (exp_cnt[ch] == 0) begin
            $display("ERROR t=%0t write to %h from channel %0d, no burst of it was due",
                     $time, addr, ch);
            other_cnt++;
            return;
        end
        e = ref_beat(ch, chk_fr[ch], chk_ix[ch]);
        if (addr !== e.addr) begin
            report_mismatch("app_addr", addr, e.addr);
        end
        if (data !== e.data) begin
            report_mismatch("app_wdf_data", data, e.data);
        end
        chk_ix[ch]++;
        exp_cnt[ch]--;
        // eight beats in a row from one channel, consecutive addresses
        if (run_cnt != 0 && (ch != run_ch || addr !== run_addr + ASIZE'(BEAT_BYTES))) begin
            $display("ERROR t=%0t burst split at beat %0d, channel %0d address %h",
                     $time, run_cnt, ch, addr);
            other_cnt++;
        end
        run_ch   = ch;
        run_addr = addr;
        run_cnt  = (run_cnt + 1) % BURST_LEN;
    endtask

    // --------------------------------------------------
    // ddr ready model
    // --------------------------------------------------
    // stall of 1 to 3 cycles, starts one cycle in four
    task automatic stall_step(inout int hold, output logic rdy);
        logic [31:0] v;
        if (hold > 0) begin
            hold--;
            rdy = 1'b0;
        end else begin
            take_bits(lfsr_rd, 2, v);
            if (v[1:0] == 2'b00) begin
                take_bits(lfsr_rd, 2, v);
                hold = ((v[1:0] == 2'b00) ? 1 : int'(v[1:0])) - 1;
                rdy  = 1'b0;
            end else begin
                rdy = 1'b1;
            end
        end
    endtask

    always @(posedge axi_m00_inf) begin
        #1;
        if (stall_en) begin
            stall_step(rdy_hold, app_rdy);
            stall_step(wdf_hold, app_wdf_rdy);
        end else begin
            app_rdy     = 1'b1;
            app_wdf_rdy = 1'b1;
        end
    end

    // --------------------------------------------------
    // comparison, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge axi_m00_inf) begin
        if (rst_n === 1'b1) begin
            if (!init_calib_complete && (app_en || app_wdf_wren)) begin
                $display("ERROR t=%0t write request before calibration finished", $time);
                other_cnt++;
            end
            if (app_wdf_end !== app_wdf_wren) begin
                report_mismatch("app_wdf_end", app_wdf_end, app_wdf_wren);
            end
            if (app_wdf_mask !== '0) begin
                report_mismatch("app_wdf_mask", app_wdf_mask, '0);
            end
            // accepts land on the coming rising edge
            if (app_en && app_rdy) begin
                if (app_cmd !== APP_WRITE) begin
                    report_mismatch("app_cmd", app_cmd, APP_WRITE);
                end
                cmd_q.push_back(app_addr);
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                dat_q.push_back(app_wdf_data);
            end
            while (cmd_q.size() > 0 && dat_q.size() > 0) begin
                check_pair(cmd_q.pop_front(), dat_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // video stimulus
    // --------------------------------------------------
    // vs cycle, then npix pixels per active channel with random gaps
    task automatic drive_frames(input logic [NUM_CH-1:0] act, input int npix);
        int          sent  [NUM_CH];
        int          taken [NUM_CH];
        logic [31:0] v;
        bit          more;
        @(posedge axi_m00_inf);
        #1;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            sent[ch]  = 0;
            taken[ch] = 0;
            if (act[ch]) begin
                frame_no[ch]++;
                base_log[ch][frame_no[ch]] = wr_baseaddr[ch];
                chk_fr[ch] = frame_no[ch];
                chk_ix[ch] = 0;
                // only whole bursts ever leave the buffer
                exp_cnt[ch] = ch_rev_enable[ch] ?
                              (npix / PIX_PER_WORD / BURST_LEN) * BURST_LEN : 0;
                vin[ch].vs  = 1'b1;
            end
        end
        more = 1'b1;
        while (more) begin
            @(posedge axi_m00_inf);
            #1;
            more = 1'b0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                vin[ch].vs = 1'b0;
                vin[ch].de = 1'b0;
                if (act[ch] && sent[ch] < npix) begin
                    take_bits(lfsr_px, 2, v);
                    // gap one cycle in four
                    if (v[1:0] != 2'b00) begin
                        take_bits(lfsr_px, PIX_W, v);
                        vin[ch].de   = 1'b1;
                        vin[ch].data = v;
                        sent[ch]++;
                        if (ch_rev_enable[ch]) begin
                            pix_log[ch][frame_no[ch]][taken[ch]] = v;
                            taken[ch]++;
                        end
                    end
                    more = 1'b1;
                end
            end
        end
    endtask

    // all due words written and the bridge idle
    task automatic wait_drain();
        while (pending_words() != 0 || app_en || app_wdf_wren) begin
            @(negedge axi_m00_inf);
        end
        // room for a stray write to show up
        repeat (20) @(negedge axi_m00_inf);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        axi_m00_inf         = 1'b0;
        rst_n               = 1'b0;
        app_rdy             = 1'b1;
        app_wdf_rdy         = 1'b1;
        init_calib_complete = 1'b0;
        stall_en            = 1'b0;
        lfsr_px             = 32'd84;
        lfsr_rd             = 32'd84;
        rdy_hold            = 0;
        wdf_hold            = 0;
        run_cnt             = 0;
        run_ch              = 0;
        run_addr            = '0;
        beat_cnt            = 0;
        mismatch_cnt        = 0;
        other_cnt           = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            ch_rev_enable[ch] = 1'b1;
            wr_baseaddr[ch]   = (ch == 0) ? ASIZE'(27'h100000) : ASIZE'(27'h200000);
            vin[ch]           = '0;
            frame_no[ch]      = -1;
            chk_fr[ch]        = 0;
            chk_ix[ch]        = 0;
            exp_cnt[ch]       = 0;
        end
        repeat (3) @(posedge axi_m00_inf);
        #1;
        rst_n = 1'b1;

        // calibration still running, words wait in the buffer
        drive_frames(2'b01, 64);
        repeat (100) @(posedge axi_m00_inf);
        #1;
        init_calib_complete = 1'b1;
        wait_drain();

        // channel 0 alone, two bursts
        drive_frames(2'b01, 64);
        wait_drain();

        // both channels at once
        drive_frames(2'b11, 64);
        wait_drain();

        // controller stalls, three spare pixels per channel
        stall_en = 1'b1;
        drive_frames(2'b11, 67);
        wait_drain();

        // channel 1 switched off
        @(posedge axi_m00_inf);
        #1;
        ch_rev_enable[1] = 1'b0;
        drive_frames(2'b11, 67);
        wait_drain();

        // new bases, the partial word before vs must vanish
        @(posedge axi_m00_inf);
        #1;
        ch_rev_enable[1] = 1'b1;
        wr_baseaddr[0]   = ASIZE'(27'h140000);
        wr_baseaddr[1]   = ASIZE'(27'h300000);
        drive_frames(2'b11, 64);
        wait_drain();
        stall_en = 1'b0;

        if (overflow !== '0) begin
            report_mismatch("overflow", overflow, '0);
        end
        if (cmd_q.size() != 0 || dat_q.size() != 0) begin
            $display("ERROR t=%0t commands and write data left unpaired", $time);
            other_cnt++;
        end

        $display("done: %0d beats, %0d mismatches, %0d other errors",
                 beat_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_CYC * 4);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* logic/multiports_vdma.sv */
`timescale 1ns/1ps

module multiports_vdma #(
    parameter int NUM_CH     = 2,
    parameter int BURST_LEN  = 8,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                             axi_m00_inf,
    input  logic                             rst_n,
    input  logic                             ch_rev_enable [NUM_CH],
    input  logic [vdma_pkg::ASIZE-1:0]       wr_baseaddr   [NUM_CH],
    input  vdma_pkg::video_in_t              vin           [NUM_CH],
    input  logic                             app_rdy,
    input  logic                             app_wdf_rdy,
    input  logic                             init_calib_complete,
    output logic [vdma_pkg::ASIZE-1:0]       app_addr,
    output vdma_pkg::app_cmd_e               app_cmd,
    output logic                             app_en,
    output logic [vdma_pkg::AXI_DSIZE-1:0]   app_wdf_data,
    output logic                             app_wdf_end,
    output logic [vdma_pkg::AXI_DSIZE/8-1:0] app_wdf_mask,
    output logic                             app_wdf_wren,
    output logic [NUM_CH-1:0]                overflow
);
    import vdma_pkg::*;

    // port side of the arbiter
    logic                 burst_req  [NUM_CH];
    logic [ASIZE-1:0]     burst_addr [NUM_CH];
    logic [AXI_DSIZE-1:0] head       [NUM_CH];
    logic                 grant      [NUM_CH];
    logic                 pop        [NUM_CH];

    // merged beat stream
    logic                 beat_valid;
    logic                 beat_ready;
    app_beat_t            beat;

    // --------------------------------------------------
    // write ports
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_CH; g++) begin : gen_port
        vdma_write_port #(
            .BURST_LEN  (BURST_LEN),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_port (
            .axi_m00_inf (axi_m00_inf),
            .rst_n       (rst_n),
            .rev_enable  (ch_rev_enable[g]),
            .wr_baseaddr (wr_baseaddr[g]),
            .vin         (vin[g]),
            .grant       (grant[g]),
            .pop         (pop[g]),
            .burst_req   (burst_req[g]),
            .burst_addr  (burst_addr[g]),
            .head        (head[g]),
            .overflow    (overflow[g])
        );
    end

    // --------------------------------------------------
    // merge and ddr side
    // --------------------------------------------------
    // grants held off until the controller is calibrated
    burst_arbiter #(
        .NUM_CH    (NUM_CH),
        .BURST_LEN (BURST_LEN)
    ) u_arbiter (
        .axi_m00_inf (axi_m00_inf),
        .rst_n       (rst_n),
        .enable      (init_calib_complete),
        .burst_req   (burst_req),
        .burst_addr  (burst_addr),
        .head        (head),
        .beat_ready  (beat_ready),
        .grant       (grant),
        .pop         (pop),
        .beat_valid  (beat_valid),
        .beat        (beat)
    );

    app_native_bridge u_bridge (
        .axi_m00_inf  (axi_m00_inf),
        .rst_n        (rst_n),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .app_rdy      (app_rdy),
        .app_wdf_rdy  (app_wdf_rdy),
        .beat_ready   (beat_ready),
        .app_addr     (app_addr),
        .app_cmd      (app_cmd),
        .app_en       (app_en),
        .app_wdf_data (app_wdf_data),
        .app_wdf_end  (app_wdf_end),
        .app_wdf_mask (app_wdf_mask),
        .app_wdf_wren (app_wdf_wren)
    );

endmodule

/* logic/app_native_bridge.sv */
`timescale 1ns/1ps

module app_native_bridge (
    input  logic                             axi_m00_inf,
    input  logic                             rst_n,
    input  logic                             beat_valid,
    input  vdma_pkg::app_beat_t              beat,
    input  logic                             app_rdy,
    input  logic                             app_wdf_rdy,
    output logic                             beat_ready,
    output logic [vdma_pkg::ASIZE-1:0]       app_addr,
    output vdma_pkg::app_cmd_e               app_cmd,
    output logic                             app_en,
    output logic [vdma_pkg::AXI_DSIZE-1:0]   app_wdf_data,
    output logic                             app_wdf_end,
    output logic [vdma_pkg::AXI_DSIZE/8-1:0] app_wdf_mask,
    output logic                             app_wdf_wren
);
    import vdma_pkg::*;

    // beat held for the controller
    app_beat_t beat_q;

    // take a new beat only once both halves are gone
    assign beat_ready = !app_en && !app_wdf_wren;

    always_ff @(posedge axi_m00_inf) begin
        if (beat_valid && beat_ready) begin
            beat_q <= beat;
        end
    end

    // --------------------------------------------------
    // command and data pending flags
    // --------------------------------------------------
    // app_en and app_wdf_wren double as the pending flags
    // each one drops on its own accept
    always_ff @(posedge axi_m00_inf or negedge rst_n) begin
        if (!rst_n) begin
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b0;
        end else if (beat_valid && beat_ready) begin
            app_en       <= 1'b1;
            app_wdf_wren <= 1'b1;
        end else begin
            if (app_en && app_rdy) begin
                app_en <= 1'b0;
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                app_wdf_wren <= 1'b0;
            end
        end
    end

    // single-beat bursts on the data channel, no byte masking
    assign app_cmd      = APP_WRITE;
    assign app_addr     = beat_q.addr;
    assign app_wdf_data = beat_q.data;
    assign app_wdf_end  = app_wdf_wren;
    assign app_wdf_mask = '0;

    // controller may sample either half late
    a_hold_stable: assert property (@(posedge axi_m00_inf) disable iff (!rst_n)
        (app_en && !app_rdy) || (app_wdf_wren && !app_wdf_rdy)
        |=> $stable(app_addr) && $stable(app_wdf_data));

endmodule

/* logic/burst_arbiter.sv */
`timescale 1ns/1ps

module burst_arbiter #(
    parameter int NUM_CH    = 2,
    parameter int BURST_LEN = 8
) (
    input  logic                           axi_m00_inf,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic                           burst_req  [NUM_CH],
    input  logic [vdma_pkg::ASIZE-1:0]     burst_addr [NUM_CH],
    input  logic [vdma_pkg::AXI_DSIZE-1:0] head       [NUM_CH],
    input  logic                           beat_ready,
    output logic                           grant      [NUM_CH],
    output logic                           pop        [NUM_CH],
    output logic                           beat_valid,
    output vdma_pkg::app_beat_t            beat
);
    import vdma_pkg::*;

    localparam int CW = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int IW = $clog2(BURST_LEN);

    arb_state_e        state;
    // search starts here
    logic [CW-1:0]     rr_ptr;
    // channel owning the current burst
    logic [CW-1:0]     chan;
    logic [ASIZE-1:0]  base_addr;
    // beat index inside the burst
    logic [IW-1:0]     idx;
    logic [NUM_CH-1:0] grant_q;
    logic [CW-1:0]     pick;
    logic              found;
    logic              beat_fire;

    // --------------------------------------------------
    // round robin pick
    // --------------------------------------------------
    // walk down so the channel nearest rr_ptr is taken last
    always_comb begin
        pick  = rr_ptr;
        found = 1'b0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (burst_req[(int'(rr_ptr) + i) % NUM_CH]) begin
                pick  = CW'((int'(rr_ptr) + i) % NUM_CH);
                found = 1'b1;
            end
        end
    end

    assign beat_fire = beat_valid && beat_ready;

    // --------------------------------------------------
    // burst FSM
    // --------------------------------------------------
    always_ff @(posedge axi_m00_inf or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            rr_ptr     <= '0;
            chan       <= '0;
            base_addr  <= '0;
            idx        <= '0;
            grant_q    <= '0;
            beat_valid <= 1'b0;
        end else begin
            // grant is a single-cycle pulse
            grant_q <= '0;
            case (state)
                ARB_IDLE: begin
                    // nothing moves before calibration is done
                    if (enable && found) begin
                        state         <= ARB_BURST;
                        chan          <= pick;
                        base_addr     <= burst_addr[pick];
                        idx           <= '0;
                        grant_q[pick] <= 1'b1;
                        rr_ptr        <= (pick == CW'(NUM_CH - 1)) ? '0 : pick + 1'b1;
                    end
                end
                ARB_BURST: begin
                    if (|grant_q) begin
                        beat_valid <= 1'b1;
                    end else if (beat_fire) begin
                        idx <= idx + 1'b1;
                        // last beat of the burst
                        if (idx == IW'(BURST_LEN - 1)) begin
                            beat_valid <= 1'b0;
                            state      <= ARB_IDLE;
                        end
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // beat out and per channel strobes
    // --------------------------------------------------
    always_comb begin
        beat.addr = base_addr + ASIZE'(idx) * ASIZE'(BEAT_BYTES);
        beat.data = head[chan];
    end

    for (genvar g = 0; g < NUM_CH; g++) begin : gen_strobe
        assign grant[g] = grant_q[g];
        // head word leaves with the beat
        assign pop[g]   = beat_fire && (chan == CW'(g));
    end

    // single owner that asked for a burst after calibration
    a_one_grant: assert property (@(posedge axi_m00_inf) disable iff (!rst_n)
        |grant_q |-> $onehot(grant_q) && burst_req[chan] && $past(enable));

endmodule

/* logic/vdma_write_port.sv */
`timescale 1ns/1ps

module vdma_write_port #(
    parameter int BURST_LEN  = 8,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                           axi_m00_inf,
    input  logic                           rst_n,
    input  logic                           rev_enable,
    input  logic [vdma_pkg::ASIZE-1:0]     wr_baseaddr,
    input  vdma_pkg::video_in_t            vin,
    input  logic                           grant,
    input  logic                           pop,
    output logic                           burst_req,
    output logic [vdma_pkg::ASIZE-1:0]     burst_addr,
    output logic [vdma_pkg::AXI_DSIZE-1:0] head,
    output logic                           overflow
);
    import vdma_pkg::*;

    localparam int LW = $clog2(FIFO_DEPTH + 1);

    video_in_t            pix;
    logic                 word_valid;
    logic [AXI_DSIZE-1:0] word;
    logic [LW-1:0]        level;

    // pixels only count while the channel is enabled
    // vs passes regardless so a frame can restart
    always_comb begin
        pix    = vin;
        pix.de = vin.de & rev_enable;
    end

    // --------------------------------------------------
    // packing and buffering
    // --------------------------------------------------
    pixel_packer u_packer (
        .axi_m00_inf (axi_m00_inf),
        .rst_n       (rst_n),
        .pix         (pix),
        .word_valid  (word_valid),
        .word        (word)
    );

    // vs empties the buffer, leftovers of the last frame are lost
    word_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .axi_m00_inf (axi_m00_inf),
        .rst_n       (rst_n),
        .clear       (vin.vs),
        .push        (word_valid),
        .din         (word),
        .pop         (pop),
        .head        (head),
        .level       (level),
        .overflow    (overflow)
    );

    // a whole burst waiting
    assign burst_req = (level >= LW'(BURST_LEN));

    // --------------------------------------------------
    // write address counter
    // --------------------------------------------------
    // arbiter latches the old value on the grant edge
    always_ff @(posedge axi_m00_inf or negedge rst_n) begin
        if (!rst_n) begin
            burst_addr <= '0;
        end else if (vin.vs) begin
            burst_addr <= wr_baseaddr;
        end else if (grant) begin
            burst_addr <= burst_addr + ASIZE'(BURST_LEN * BEAT_BYTES);
        end
    end

endmodule

/* logic/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
    parameter int DEPTH = 32
) (
    input  logic                           axi_m00_inf,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           push,
    input  logic [vdma_pkg::AXI_DSIZE-1:0] din,
    input  logic                           pop,
    output logic [vdma_pkg::AXI_DSIZE-1:0] head,
    output logic [$clog2(DEPTH+1)-1:0]     level,
    output logic                           overflow
);
    import vdma_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LW = $clog2(DEPTH + 1);

    logic [AXI_DSIZE-1:0] mem [DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    // circular pointer step
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (level == LW'(DEPTH));
    // clear wins over a push or pop in the same cycle
    assign wr_en = push && !full && !clear;
    assign rd_en = pop && (level != '0) && !clear;
    // front word, read straight from the array
    assign head  = mem[rd_ptr];

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge axi_m00_inf) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------------------------------------
    // pointers, level, overflow
    // --------------------------------------------------
    always_ff @(posedge axi_m00_inf or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            // word lost on a full buffer, held until reset
            if (push && full && !clear) begin
                overflow <= 1'b1;
            end
            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                level  <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (rd_en) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                level <= level + LW'(wr_en) - LW'(rd_en);
            end
        end
    end

    // arbiter only streams from a channel holding a full burst
    a_no_pop_empty: assert property (@(posedge axi_m00_inf) disable iff (!rst_n)
        pop |-> (level != '0));

endmodule

/* logic/pixel_packer.sv */
`timescale 1ns/1ps

module pixel_packer (
    input  logic                           axi_m00_inf,
    input  logic                           rst_n,
    input  vdma_pkg::video_in_t            pix,
    output logic                           word_valid,
    output logic [vdma_pkg::AXI_DSIZE-1:0] word
);
    import vdma_pkg::*;

    localparam int CW = $clog2(PIX_PER_WORD);

    // pixels already in the current word
    logic [CW-1:0] cnt;
    logic          last_pix;

    // fourth pixel of a word, a vs cycle always starts a new word
    assign last_pix = pix.de && !pix.vs && (cnt == CW'(PIX_PER_WORD - 1));

    // --------------------------------------------------
    // shift register
    // --------------------------------------------------
    // new pixel enters at the top and walks down
    // so pixel 0 ends up in the low bits
    always_ff @(posedge axi_m00_inf) begin
        if (pix.de) begin
            word <= {pix.data, word[AXI_DSIZE-1:PIX_W]};
        end
    end

    // --------------------------------------------------
    // pixel counter
    // --------------------------------------------------
    always_ff @(posedge axi_m00_inf or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            word_valid <= 1'b0;
        end else begin
            // full word shows up one cycle after its last pixel
            word_valid <= last_pix;
            if (pix.vs) begin
                // drop any partial word of the old frame
                cnt <= pix.de ? CW'(1) : '0;
            end else if (pix.de) begin
                // wraps at PIX_PER_WORD
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/vdma_pkg.sv */
package vdma_pkg;

    // --------------------------------------------------
    // memory side widths
    // --------------------------------------------------
    // ddr address width
    localparam int ASIZE        = 27;
    // one memory word
    localparam int AXI_DSIZE    = 128;
    // one pixel
    localparam int PIX_W        = 32;
    // pixel 0 of a word sits in the lowest bits
    localparam int PIX_PER_WORD = AXI_DSIZE / PIX_W;
    // address step per word
    localparam int BEAT_BYTES   = AXI_DSIZE / 8;

    // --------------------------------------------------
    // shared types
    // --------------------------------------------------
    // native video, vs is a one-cycle frame start
    typedef struct packed {
        logic             vs;
        logic             de;
        logic [PIX_W-1:0] data;
    } video_in_t;

    // one write beat towards the ddr controller
    typedef struct packed {
        logic [ASIZE-1:0]     addr;
        logic [AXI_DSIZE-1:0] data;
    } app_beat_t;

    // native app command codes, only writes go out
    typedef enum logic [2:0] {
        APP_WRITE = 3'd0,
        APP_READ  = 3'd1
    } app_cmd_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_BURST
    } arb_state_e;

endpackage
